// File: Makefile
# Verilator build and run of the pixel feeder testbench

VERILATOR ?= verilator
TOP       ?= pixel_feeder_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
source/pixel_pkg.sv
source/pixel_fetch_gen.sv
source/pixel_unpack_fifo.sv
source/pixel_output_stage.sv
source/feeder_regs.sv
source/pixel_feeder.sv
test/pixel_feeder_chk.sv
test/pixel_feeder_tb.sv

// File: source/feeder_regs.sv
// AXI4-Lite slave with control, frame done status, interrupt and frame counter
`timescale 1ns/10ps
`default_nettype none

module feeder_regs
   import pixel_pkg::*;
(
   input  logic      cpu_clk_g,
   input  logic      rst,
   input  logic      awvalid,
   input  axi_addr_t awaddr,
   input  logic      wvalid,
   input  axi_data_t wdata,
   input  logic      bready,
   output logic      awready,
   output logic      wready,
   output logic      bvalid,
   output logic [1:0] bresp,
   input  logic      arvalid,
   input  axi_addr_t araddr,
   output logic      arready,
   input  logic      rready,
   output logic      rvalid,
   output axi_data_t rdata,
   output logic [1:0] rresp,
   input  logic      frame_end,
   output logic      enable,
   output logic      buf_sel,
   output logic      frame_interrupt
);

   logic [1:0] ctrl;
   logic       done;
   axi_data_t  frames;
   logic       wr_fire;
   logic       rd_fire;
   logic       done_clr;

   // address and data taken together, one write in flight
   assign wr_fire = awvalid && wvalid && !bvalid;
   assign awready = wr_fire;
   assign wready  = wr_fire;
   assign rd_fire = arvalid && !rvalid;
   assign arready = !rvalid;

   // always OKAY
   assign bresp = 2'b00;
   assign rresp = 2'b00;

   assign enable          = ctrl[0];
   assign buf_sel         = ctrl[1];
   assign frame_interrupt = done;
   assign done_clr        = wr_fire && (awaddr == REG_STATUS) && wdata[0];

   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         ctrl   <= '0;
         done   <= 1'b0;
         frames <= '0;
         bvalid <= 1'b0;
      end else begin
         if (wr_fire && (awaddr == REG_CTRL)) begin
            ctrl <= wdata[1:0];
         end
         // a new frame end wins over a clear
         if (frame_end) begin
            done <= 1'b1;
         end else if (done_clr) begin
            done <= 1'b0;
         end
         if (frame_end) begin
            frames <= frames + 1'b1;
         end
         if (wr_fire) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   // read response
   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         rvalid <= 1'b0;
      end else if (rd_fire) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   always_ff @(posedge cpu_clk_g) begin
      if (rd_fire) begin
         case (araddr)
            REG_CTRL:   rdata <= {30'd0, ctrl};
            REG_STATUS: rdata <= {31'd0, done};
            REG_FRAMES: rdata <= frames;
            default:    rdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/pixel_feeder.sv
// top level: fetch, unpack fifo, output stage and register block
`timescale 1ns/10ps
`default_nettype none

module pixel_feeder
   import pixel_pkg::*;
(
   input  logic       cpu_clk_g,
   input  logic       rst,
   // ddr request and return fifos
   input  logic       af_full,
   output logic       af_wr_en,
   output ddr_addr_t  af_addr_din,
   input  logic       rdf_valid,
   input  ddr_word_t  rdf_dout,
   output logic       rdf_rd_en,
   // display sink
   output video_t     video,
   output logic       video_valid,
   input  logic       video_ready,
   // register port
   input  logic       awvalid,
   input  axi_addr_t  awaddr,
   output logic       awready,
   input  logic       wvalid,
   input  axi_data_t  wdata,
   output logic       wready,
   output logic       bvalid,
   output logic [1:0] bresp,
   input  logic       bready,
   input  logic       arvalid,
   input  axi_addr_t  araddr,
   output logic       arready,
   output logic       rvalid,
   output axi_data_t  rdata,
   output logic [1:0] rresp,
   input  logic       rready,
   output logic       frame_interrupt
);

   pixel_t fifo_pix;
   logic   fifo_valid;
   logic   fifo_pop;
   logic   pix_taken;
   logic   frame_end;
   logic   enable;
   logic   buf_sel;

   // fifo always has room, so return data is always drained
   assign rdf_rd_en = 1'b1;

   pixel_fetch_gen u_fetch_gen (
      .cpu_clk_g   (cpu_clk_g),
      .rst         (rst),
      .enable      (enable),
      .buf_sel     (buf_sel),
      .af_full     (af_full),
      .pix_taken   (pix_taken),
      .af_wr_en    (af_wr_en),
      .af_addr_din (af_addr_din)
   );

   pixel_unpack_fifo u_unpack_fifo (
      .cpu_clk_g (cpu_clk_g),
      .rst       (rst),
      .wr_en     (rdf_valid),
      .din       (rdf_dout),
      .pop       (fifo_pop),
      .pix       (fifo_pix),
      .pix_valid (fifo_valid)
   );

   pixel_output_stage u_output_stage (
      .cpu_clk_g   (cpu_clk_g),
      .rst         (rst),
      .pix         (fifo_pix),
      .pix_valid   (fifo_valid),
      .video_ready (video_ready),
      .pop         (fifo_pop),
      .video_valid (video_valid),
      .video       (video),
      .pix_taken   (pix_taken),
      .frame_end   (frame_end)
   );

   feeder_regs u_regs (
      .cpu_clk_g       (cpu_clk_g),
      .rst             (rst),
      .awvalid         (awvalid),
      .awaddr          (awaddr),
      .wvalid          (wvalid),
      .wdata           (wdata),
      .bready          (bready),
      .awready         (awready),
      .wready          (wready),
      .bvalid          (bvalid),
      .bresp           (bresp),
      .arvalid         (arvalid),
      .araddr          (araddr),
      .arready         (arready),
      .rready          (rready),
      .rvalid          (rvalid),
      .rdata           (rdata),
      .rresp           (rresp),
      .frame_end       (frame_end),
      .enable          (enable),
      .buf_sel         (buf_sel),
      .frame_interrupt (frame_interrupt)
   );

endmodule

`default_nettype wire

// File: source/pixel_fetch_gen.sv
// fetch stage: frame scan, word address generation and credit-limited requests
`timescale 1ns/10ps
`default_nettype none

module pixel_fetch_gen
   import pixel_pkg::*;
(
   input  logic      cpu_clk_g,
   input  logic      rst,
   input  logic      enable,
   input  logic      buf_sel,
   input  logic      af_full,
   input  logic      pix_taken,
   output logic      af_wr_en,
   output ddr_addr_t af_addr_din
);

   fetch_state_t state;
   ddr_addr_t    base;
   col_t         col;
   row_t         row;
   credit_t      credits;
   logic         accept;
   logic         line_end;
   logic         last_word;
   logic         frame_start;

   // request only while a whole word of room is left in the fifo
   assign af_wr_en = (state == FETCH_RUN) && (credits >= credit_t'(PIX_PER_WORD));
   assign accept   = af_wr_en && !af_full;

   assign line_end    = (col == col_t'(FRAME_W - PIX_PER_WORD));
   assign last_word   = line_end && (row == row_t'(FRAME_H - 1));
   // settings are picked up only here
   assign frame_start = (state == FETCH_IDLE) || (accept && last_word);

   // base + row * words per line + word column
   assign af_addr_din = base
                      + ddr_addr_t'(row) * ddr_addr_t'(WORDS_PER_LINE)
                      + ddr_addr_t'(col / PIX_PER_WORD);

   // state and buffer base
   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         state <= FETCH_IDLE;
         base  <= FB_BASE0;
      end else if (frame_start) begin
         state <= enable ? FETCH_RUN : FETCH_IDLE;
         base  <= buf_sel ? FB_BASE1 : FB_BASE0;
      end
   end

   // raster position, one word per accepted request
   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         col <= '0;
         row <= '0;
      end else if (accept) begin
         if (line_end) begin
            col <= '0;
            // wrap to the top after the last line
            row <= (row == row_t'(FRAME_H - 1)) ? '0 : row + 1'b1;
         end else begin
            col <= col + col_t'(PIX_PER_WORD);
         end
      end
   end

   // credits: one back per pixel shown, four spent per word asked for
   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         credits <= credit_t'(PIX_CREDITS);
      end else begin
         credits <= credits
                  + credit_t'(pix_taken)
                  - (accept ? credit_t'(PIX_PER_WORD) : credit_t'(0));
      end
   end

endmodule

`default_nettype wire

// File: source/pixel_output_stage.sv
// output stage: video ready/valid handshake, credit return and frame end marker
`timescale 1ns/10ps
`default_nettype none

module pixel_output_stage
   import pixel_pkg::*;
(
   input  logic   cpu_clk_g,
   input  logic   rst,
   input  pixel_t pix,
   input  logic   pix_valid,
   input  logic   video_ready,
   output logic   pop,
   output logic   video_valid,
   output video_t video,
   output logic   pix_taken,
   output logic   frame_end
);

   pix_cnt_t pix_cnt;
   logic     take;
   logic     last_pix;

   // pixel goes out straight from the fifo head
   assign video_valid = pix_valid;
   assign video       = pix[23:0];

   assign take      = pix_valid && video_ready;
   assign pop       = take;
   // every pixel shown frees one credit upstream
   assign pix_taken = take;

   assign last_pix  = (pix_cnt == pix_cnt_t'(FRAME_PIX - 1));
   assign frame_end = take && last_pix;

   // pixels taken so far in this frame
   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         pix_cnt <= '0;
      end else if (take) begin
         pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: source/pixel_pkg.sv
// shared geometry, buffer bases, register map, vector types and fetch state enum
`default_nettype none

package pixel_pkg;

   // frame geometry, kept small for short runs
   localparam int FRAME_W        = 16;
   localparam int FRAME_H        = 6;
   localparam int FRAME_PIX      = FRAME_W * FRAME_H;
   localparam int PIX_PER_WORD   = 4;
   localparam int WORDS_PER_LINE = FRAME_W / PIX_PER_WORD;

   // unpack fifo sizing
   localparam int FIFO_WORDS  = 8;
   localparam int FIFO_AW     = $clog2(FIFO_WORDS);
   localparam int PIX_CREDITS = FIFO_WORDS * PIX_PER_WORD;

   // vectors with a meaning of their own
   typedef logic [30:0]  ddr_addr_t;
   typedef logic [127:0] ddr_word_t;
   typedef logic [31:0]  pixel_t;
   typedef logic [23:0]  video_t;
   typedef logic [3:0]   col_t;
   typedef logic [2:0]   row_t;
   typedef logic [5:0]   credit_t;
   typedef logic [6:0]   pix_cnt_t;
   typedef logic [3:0]   axi_addr_t;
   typedef logic [31:0]  axi_data_t;

   // frame buffer word addresses, byte address >> 4
   localparam ddr_addr_t FB_BASE0 = 31'h0001_0000;
   localparam ddr_addr_t FB_BASE1 = 31'h0002_0000;

   // register map
   localparam axi_addr_t REG_CTRL   = 4'h0;
   localparam axi_addr_t REG_STATUS = 4'h4;
   localparam axi_addr_t REG_FRAMES = 4'h8;

   typedef enum logic {
      FETCH_IDLE,
      FETCH_RUN
   } fetch_state_t;

endpackage

`default_nettype wire

// File: source/pixel_unpack_fifo.sv
// unpack stage: word fifo that hands out each 128-bit word as four pixels
`timescale 1ns/10ps
`default_nettype none

module pixel_unpack_fifo
   import pixel_pkg::*;
(
   input  logic      cpu_clk_g,
   input  logic      rst,
   input  logic      wr_en,
   input  ddr_word_t din,
   input  logic      pop,
   output pixel_t    pix,
   output logic      pix_valid
);

   // word storage
   ddr_word_t words [FIFO_WORDS];

   // extra msb tells full from empty
   logic [FIFO_AW:0]   wr_ptr;
   logic [FIFO_AW:0]   rd_ptr;
   logic [FIFO_AW:0]   level;
   logic [1:0]         lane;
   logic               take;
   logic               word_done;
   ddr_word_t          head;

   assign level     = wr_ptr - rd_ptr;
   assign pix_valid = (level != '0);
   assign take      = pop && pix_valid;
   assign word_done = take && (lane == 2'd3);

   // head word, lane 0 sits in the low bits
   assign head = words[rd_ptr[FIFO_AW-1:0]];
   assign pix  = head[lane * $bits(pixel_t) +: $bits(pixel_t)];

   // no back-pressure here, credits keep room for every write
   always_ff @(posedge cpu_clk_g) begin
      if (wr_en) begin
         words[wr_ptr[FIFO_AW-1:0]] <= din;
      end
   end

   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         wr_ptr <= '0;
      end else if (wr_en) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // lane walks 0..3 across the head word
   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         lane <= '0;
      end else if (take) begin
         lane <= lane + 1'b1;
      end
   end

   // drop the head word once its last lane is gone
   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         rd_ptr <= '0;
      end else if (word_done) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: test/pixel_feeder_chk.sv
// bound assertions: request address hold, video hold, unpack fifo overflow
`timescale 1ns/10ps
`default_nettype none

module pixel_feeder_chk
   import pixel_pkg::*;
(
   input logic      cpu_clk_g,
   input logic      rst,
   input logic      af_wr_en,
   input logic      af_full,
   input ddr_addr_t af_addr_din,
   input logic      rdf_valid,
   input logic      video_valid,
   input logic      video_ready,
   input video_t    video
);

   // fifo occupancy rebuilt from the ports, four pixels drain one word
   int words_in;
   int pix_out;
   int held;

   assign held = words_in - pix_out / PIX_PER_WORD;

   always @(posedge cpu_clk_g) begin
      if (rst) begin
         words_in <= 0;
         pix_out  <= 0;
      end else begin
         if (rdf_valid) begin
            words_in <= words_in + 1;
         end
         if (video_valid && video_ready) begin
            pix_out <= pix_out + 1;
         end
      end
   end

   af_addr_hold: assert property (@(posedge cpu_clk_g) disable iff (rst)
      (af_wr_en && af_full) |=> $stable(af_addr_din))
      else $error("request address changed while the request fifo was full");

   video_hold: assert property (@(posedge cpu_clk_g) disable iff (rst)
      (video_valid && !video_ready) |=> $stable(video))
      else $error("video changed while the sink was stalling");

   // credits must keep a free word for every return
   fifo_room: assert property (@(posedge cpu_clk_g) disable iff (rst)
      rdf_valid |-> (held < FIFO_WORDS))
      else $error("read data arrived while the unpack fifo was full");

endmodule

bind pixel_feeder pixel_feeder_chk u_feeder_chk (
   .cpu_clk_g   (cpu_clk_g),
   .rst         (rst),
   .af_wr_en    (af_wr_en),
   .af_full     (af_full),
   .af_addr_din (af_addr_din),
   .rdf_valid   (rdf_valid),
   .video_valid (video_valid),
   .video_ready (video_ready),
   .video       (video)
);

`default_nettype wire

// File: test/pixel_feeder_tb.sv
// pixel_feeder testbench with clock, reset, ddr read model, axi tasks, reference and compare
`timescale 1ns/10ps
`default_nettype none

module pixel_feeder_tb
   import pixel_pkg::*;
();

   // four frames at three cycles a pixel, plus reset, register traffic and idle check
   localparam int TIMEOUT_CYCLES = 4 * FRAME_PIX * 3 + 2848;
   localparam int SHOW_FRAMES    = 3;

   logic       cpu_clk_g;
   logic       rst;
   logic       af_full;
   logic       af_wr_en;
   ddr_addr_t  af_addr_din;
   logic       rdf_valid;
   ddr_word_t  rdf_dout;
   logic       rdf_rd_en;
   video_t     video;
   logic       video_valid;
   logic       video_ready;
   logic       awvalid;
   axi_addr_t  awaddr;
   logic       awready;
   logic       wvalid;
   axi_data_t  wdata;
   logic       wready;
   logic       bvalid;
   logic [1:0] bresp;
   logic       bready;
   logic       arvalid;
   axi_addr_t  araddr;
   logic       arready;
   logic       rvalid;
   axi_data_t  rdata;
   logic [1:0] rresp;
   logic       rready;
   logic       frame_interrupt;

   int        seed = 32'h669e_2fd2;
   int        cyc = 0;
   // pixels seen at the video port so far
   int        shown = 0;
   // accepted requests waiting for their data
   ddr_addr_t pend_addr[$];
   int        pend_due[$];

   pixel_feeder u_pixel_feeder (.*);

   initial begin : clock_gen
      cpu_clk_g = 1'b0;
      forever #20 cpu_clk_g = ~cpu_clk_g;
   end

   // expected colour from the address rule and the memory data rule
   function automatic video_t ref_pixel(input logic sel, input int index);
      int row;
      int col;
      int word_addr;
      row       = index / FRAME_W;
      col       = index % FRAME_W;
      word_addr = (sel ? 32'h0020_0000 : 32'h0010_0000) >> 4;
      word_addr = word_addr + row * WORDS_PER_LINE + col / PIX_PER_WORD;
      return {word_addr[21:0], 2'(col)};
   endfunction

   // memory contents, lane 0 in the low bits
   function automatic ddr_word_t mem_word(input ddr_addr_t addr);
      ddr_word_t w;
      for (int i = 0; i < PIX_PER_WORD; i++) begin
         w[32*i +: 32] = {8'h00, addr[21:0], 2'(i)};
      end
      return w;
   endfunction

   task automatic end_with_failure;
      $display("=== FAIL ===");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_video(input video_t got, input video_t exp);
      if (got !== exp) begin
         $display("error: video got %h expected %h at pixel %0d", got, exp, shown);
         end_with_failure();
      end
   endtask

   task automatic check_reg(input string name, input axi_data_t got, input axi_data_t exp);
      if (got !== exp) begin
         $display("error: %s got %h expected %h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] got);
      if (got !== 2'b00) begin
         $display("error: %s got %h expected %h", name, got, 2'b00);
         end_with_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error: %s got %h expected %h", name, got, exp);
         end_with_failure();
      end
   endtask

   // one AXI4-Lite write, address and data together
   task automatic write_reg(input axi_addr_t addr, input axi_data_t data);
      @(negedge cpu_clk_g);
      awvalid = 1'b1;
      awaddr  = addr;
      wvalid  = 1'b1;
      wdata   = data;
      bready  = 1'b1;
      #1;
      while (!awready) begin
         @(negedge cpu_clk_g);
         #1;
      end
      // data channel is taken in the same cycle as the address
      check_bit("wready", wready, 1'b1);
      @(negedge cpu_clk_g);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      #1;
      while (!bvalid) begin
         @(negedge cpu_clk_g);
         #1;
      end
      check_resp("bresp", bresp);
      @(negedge cpu_clk_g);
      bready = 1'b0;
   endtask

   // one AXI4-Lite read, compared with exp
   task automatic read_reg(input string name, input axi_addr_t addr, input axi_data_t exp);
      @(negedge cpu_clk_g);
      arvalid = 1'b1;
      araddr  = addr;
      rready  = 1'b1;
      #1;
      while (!arready) begin
         @(negedge cpu_clk_g);
         #1;
      end
      @(negedge cpu_clk_g);
      arvalid = 1'b0;
      #1;
      while (!rvalid) begin
         @(negedge cpu_clk_g);
         #1;
      end
      check_resp("rresp", rresp);
      check_reg(name, rdata, exp);
      @(negedge cpu_clk_g);
      rready = 1'b0;
   endtask

   // wait for the interrupt, check status and count, then clear it
   task automatic service_frame(input axi_data_t frames_exp);
      #1;
      while (!frame_interrupt) begin
         @(negedge cpu_clk_g);
         #1;
      end
      read_reg("status", REG_STATUS, 32'd1);
      read_reg("frames", REG_FRAMES, frames_exp);
      write_reg(REG_STATUS, 32'd1);
      #1;
      check_bit("frame_interrupt", frame_interrupt, 1'b0);
      read_reg("status", REG_STATUS, 32'd0);
   endtask

   task automatic wait_shown(input int count);
      while (shown < count) begin
         @(negedge cpu_clk_g);
      end
   endtask

   // ddr model with random request back-pressure and in-order return after 1..6 cycles
   // the display sink stalls at random from the same stream
   initial begin : ddr_model
      int delay;
      af_full     = 1'b0;
      rdf_valid   = 1'b0;
      rdf_dout    = '0;
      video_ready = 1'b0;
      forever begin
         @(negedge cpu_clk_g);
         rdf_valid = 1'b0;
         if (pend_addr.size() != 0 && pend_due[0] <= cyc) begin
            rdf_valid = 1'b1;
            rdf_dout  = mem_word(pend_addr.pop_front());
            void'(pend_due.pop_front());
         end
         af_full = (($random(seed) & 3) == 0);
         // taken at the coming rising edge
         if (af_wr_en && !af_full) begin
            delay = 1 + (($random(seed) & 32'h7fff_ffff) % 6);
            pend_addr.push_back(af_addr_din);
            pend_due.push_back(cyc + 1 + delay);
         end
         video_ready = (($random(seed) & 1) == 1);
      end
   end

   // first frame from buffer 0, later ones from buffer 1
   initial begin : compare_video
      int frame_no;
      int idx;
      forever begin
         @(negedge cpu_clk_g);
         #1;
         if (video_valid && video_ready) begin
            if (shown >= SHOW_FRAMES * FRAME_PIX) begin
               $display("a pixel appeared after the feeder was disabled");
               end_with_failure();
            end
            frame_no = shown / FRAME_PIX;
            idx      = shown % FRAME_PIX;
            check_video(video, ref_pixel(frame_no != 0, idx));
            shown = shown + 1;
         end
      end
   end

   initial begin : watchdog
      forever begin
         @(posedge cpu_clk_g);
         cyc = cyc + 1;
         if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
         end
      end
   end

   initial begin : run_tests
      rst     = 1'b1;
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b0;
      repeat (16) @(negedge cpu_clk_g);
      rst = 1'b0;
      #1;
      check_bit("af_wr_en", af_wr_en, 1'b0);
      check_bit("video_valid", video_valid, 1'b0);
      check_bit("frame_interrupt", frame_interrupt, 1'b0);
      check_bit("bvalid", bvalid, 1'b0);
      check_bit("rvalid", rvalid, 1'b0);
      // return data is always drained
      check_bit("rdf_rd_en", rdf_rd_en, 1'b1);

      // enable with buffer 0
      write_reg(REG_CTRL, 32'd1);
      read_reg("ctrl", REG_CTRL, 32'd1);
      // switch buffer early in frame 0 while fetch is still inside it
      wait_shown(16);
      write_reg(REG_CTRL, 32'd3);
      read_reg("ctrl", REG_CTRL, 32'd3);
      service_frame(32'd1);
      service_frame(32'd2);
      // disable early in frame 2 so frame 2 is the last one fetched
      wait_shown(2 * FRAME_PIX + 16);
      write_reg(REG_CTRL, 32'd2);
      read_reg("ctrl", REG_CTRL, 32'd2);
      service_frame(32'd3);

      // feeder must stay quiet now
      repeat (300) begin
         @(negedge cpu_clk_g);
         #1;
         check_bit("af_wr_en", af_wr_en, 1'b0);
         check_bit("video_valid", video_valid, 1'b0);
      end
      if (shown != SHOW_FRAMES * FRAME_PIX || pend_addr.size() != 0) begin
         $display("pixel count %0d or outstanding requests %0d are wrong",
                  shown, pend_addr.size());
         end_with_failure();
      end
      read_reg("frames", REG_FRAMES, 32'd3);
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire
